//--- game_core.f
+incdir+hw
hw/game_pkg.sv
hw/rom_req_if.sv
hw/cen_gen.sv
hw/video_timing.sv
hw/rom_arbiter.sv
hw/text_layer.sv
hw/game_core.sv
bench/sdram_model.sv
bench/tb_game_core.sv

//--- Makefile
# Verilator flow, run from the project root
TOP = tb_game_core
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module game_core -f game_core.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f game_core.f --Mdir $(OBJ) -o sim_$(TOP)
	./$(OBJ)/sim_$(TOP)

clean:
	rm -rf $(OBJ)

//--- bench/tb_game_core.sv
// four frames, the last two flipped, with program reads throughout; stops at the first failure
`timescale 1ns/1ps
`include "game_defines.svh"

module tb_game_core;

    localparam int WATCH_CLKS = 6 * `H_TOTAL * `V_TOTAL * `PXL_DIV;
    // one text fetch and a burst in flight plus margin
    localparam int PROG_WAIT_MAX = (`LINE_WORDS + 2) * 12;

    logic        clk;
    logic        rst_n;
    logic        flip;
    logic        pxl_cen;
    logic        LHBL;
    logic        LVBL;
    logic        HS;
    logic        VS;
    logic [3:0]  pixel;
    logic        prog_cs;
    logic [20:0] prog_addr;
    logic        prog_ok;
    logic [31:0] prog_dout;
    logic [21:0] ba_addr;
    logic        ba_rd;
    logic        ba_ack;
    logic        ba_dok;
    logic        ba_rdy;
    logic [15:0] data_read;

    integer      seed = 32'h6b6c;
    bit          cen_seen = 0;
    bit          lhbl_q = 0;
    bit          lvbl_q = 0;
    bit          line_seen = 0;
    bit          frame_seen = 0;
    int          cen_gap = 0;
    int          h_cnt = 0;
    int          act_cnt = 0;
    int          line_cnt = 0;
    int          vact_cnt = 0;
    int          x = 0;
    int          y = 0;
    int          act_frames = 0;
    int          n_pix = 0;
    int          n_prog = 0;
    logic [3:0]  exp_pix = 4'd0;

    game_core dut_i (.*);
    sdram_model u_sdram (.*);

    // ROM word w is built from SDRAM words 2w and 2w+1
    function automatic logic [31:0] rom_word_at(input logic [20:0] w);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = {w[14:0], 1'b0} ^ 16'h5a5a;
        hi = {w[14:0], 1'b1} ^ 16'h5a5a;
        return {hi, lo};
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s at t=%0t", what, $time);
        abort_run();
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // video checks on values sampled at the rising edge
    always @(posedge clk) begin : check_video
        int          src;
        logic [31:0] word;
        if (rst_n) begin
            if (!cen_seen) begin
                assert (!ba_rd && !prog_ok && !HS && !VS && !LHBL && !LVBL)
                    else report_problem("outputs not low before the first pixel enable");
            end
            assert (!(HS && LHBL)) else report_problem("HS high outside horizontal blank");
            assert (!(VS && LVBL)) else report_problem("VS high outside vertical blank");
            if (pxl_cen) begin
                if (cen_seen) begin
                    assert (cen_gap == `PXL_DIV)
                        else value_mismatch("pxl_cen gap", cen_gap, `PXL_DIV);
                end
                cen_seen = 1;
                cen_gap = 1;
                assert (pixel == exp_pix) else value_mismatch("pixel", pixel, exp_pix);
                // new line on a rising LHBL and new frame when LVBL rises with it
                if (LHBL && !lhbl_q) begin
                    if (line_seen) begin
                        assert (h_cnt == `H_TOTAL)
                            else value_mismatch("enables per line", h_cnt, `H_TOTAL);
                        assert (act_cnt == `H_ACTIVE)
                            else value_mismatch("LHBL high count", act_cnt, `H_ACTIVE);
                    end
                    line_seen = 1;
                    h_cnt = 0;
                    act_cnt = 0;
                    if (LVBL && !lvbl_q) begin
                        if (frame_seen) begin
                            assert (line_cnt == `V_TOTAL)
                                else value_mismatch("lines per frame", line_cnt, `V_TOTAL);
                            assert (vact_cnt == `V_ACTIVE)
                                else value_mismatch("LVBL high lines", vact_cnt, `V_ACTIVE);
                        end
                        frame_seen = 1;
                        line_cnt = 0;
                        vact_cnt = 0;
                        y = 0;
                    end else begin
                        y = y + 1;
                    end
                    line_cnt = line_cnt + 1;
                    vact_cnt = vact_cnt + (LVBL ? 1 : 0);
                end
                h_cnt = h_cnt + 1;
                act_cnt = act_cnt + (LHBL ? 1 : 0);
                if (LHBL && LVBL) begin
                    src = flip ? (`H_ACTIVE - 1 - x) : x;
                    word = rom_word_at(21'(`TEXT_BASE + y * `LINE_WORDS + src / 8));
                    exp_pix = word[4 * (src % 8) +: 4];
                    n_pix = n_pix + 1;
                end else begin
                    exp_pix = 4'd0;
                end
                x = LHBL ? x + 1 : 0;
                if (!LVBL && lvbl_q) begin
                    act_frames = act_frames + 1;
                end
                lhbl_q = LHBL;
                lvbl_q = LVBL;
            end else begin
                cen_gap = cen_gap + 1;
            end
        end
    end

    // program reads at random addresses compete with text fetches
    initial begin : prog_reads
        logic [20:0] addr;
        int          waited;
        wait (cen_seen);
        forever begin
            @(posedge clk);
            addr = 21'($random(seed));
            prog_addr <= addr;
            prog_cs <= 1'b1;
            waited = 0;
            @(posedge clk);
            while (!prog_ok) begin
                waited = waited + 1;
                if (waited > PROG_WAIT_MAX) begin
                    report_problem("program read never answered");
                end else begin
                    @(posedge clk);
                end
            end
            assert (prog_dout == rom_word_at(addr))
                else value_mismatch("prog_dout", prog_dout, rom_word_at(addr));
            prog_cs <= 1'b0;
            n_prog = n_prog + 1;
            repeat ($unsigned($random(seed)) % 8) @(posedge clk);
        end
    end

    initial begin
        rst_n = 1'b0;
        flip = 1'b0;
        prog_cs = 1'b0;
        prog_addr = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        wait (act_frames == 2);
        @(posedge clk);
        flip <= 1'b1;
        wait (act_frames == 4);
        @(posedge clk);
        if (n_prog > 0 && n_pix == 4 * `V_ACTIVE * `H_ACTIVE) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            report_problem("stimulus did not reach every check");
        end
    end

    initial begin
        repeat (WATCH_CLKS) @(posedge clk);
        report_problem("watchdog expired, the run hung");
    end

endmodule

//--- bench/sdram_model.sv
// one read at a time; ack 1 to 4 cycles after ba_rd, then two beats one cycle apart
`timescale 1ns/1ps

module sdram_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [21:0] ba_addr,
    input  logic        ba_rd,
    output logic        ba_ack,
    output logic        ba_dok,
    output logic        ba_rdy,
    output logic [15:0] data_read
);

    typedef enum logic [1:0] {IDLE, WAIT_ACK, BEAT_LO, BEAT_HI} phase_t;

    integer      seed = 32'h6b6c;
    phase_t      phase;
    logic [2:0]  delay;
    logic [21:0] addr_q;

    // contents of the bank at 16-bit word a
    function automatic logic [15:0] beat_data(input logic [21:0] a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= IDLE;
            delay     <= 3'd0;
            addr_q    <= '0;
            ba_ack    <= 1'b0;
            ba_dok    <= 1'b0;
            ba_rdy    <= 1'b0;
            data_read <= 16'd0;
        end else begin
            ba_ack <= 1'b0;
            ba_dok <= 1'b0;
            ba_rdy <= 1'b0;
            case (phase)
                IDLE: begin
                    if (ba_rd) begin
                        delay  <= {1'b0, 2'($random(seed))} + 3'd1;
                        addr_q <= ba_addr;
                        phase  <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (delay == 3'd1) begin
                        ba_ack <= 1'b1;
                        phase  <= BEAT_LO;
                    end else begin
                        delay <= delay - 3'd1;
                    end
                end
                BEAT_LO: begin
                    ba_dok    <= 1'b1;
                    data_read <= beat_data(addr_q);
                    phase     <= BEAT_HI;
                end
                default: begin
                    // second beat closes the burst
                    ba_dok    <= 1'b1;
                    ba_rdy    <= 1'b1;
                    data_read <= beat_data(addr_q | 22'd1);
                    phase     <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/game_core.sv
// text-only core, 4-bit pixel index out, one SDRAM bank shared by text and program reads
`timescale 1ns/1ps
`include "game_defines.svh"

module game_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flip,
    output logic                  pxl_cen,
    output logic                  LHBL,
    output logic                  LVBL,
    output logic                  HS,
    output logic                  VS,
    output logic [3:0]            pixel,
    // program read port
    input  logic                  prog_cs,
    input  game_pkg::rom_addr_t   prog_addr,
    output logic                  prog_ok,
    output game_pkg::rom_word_t   prog_dout,
    // SDRAM bank
    output game_pkg::sdram_addr_t ba_addr,
    output logic                  ba_rd,
    input  logic                  ba_ack,
    input  logic                  ba_dok,
    input  logic                  ba_rdy,
    input  logic [15:0]           data_read
);

    logic [`V_W-1:0] v;

    rom_req_if video_if ();
    rom_req_if prog_if ();

    assign prog_if.cs   = prog_cs;
    assign prog_if.addr = prog_addr;
    assign prog_ok      = prog_if.ok;
    assign prog_dout    = prog_if.dout;

    cen_gen u_cen (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen)
    );

    video_timing u_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .HS      (HS),
        .VS      (VS),
        .v       (v)
    );

    text_layer u_text (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .flip    (flip),
        .v       (v),
        .rom     (video_if.client),
        .pixel   (pixel)
    );

    rom_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .video     (video_if.arbiter),
        .prog      (prog_if.arbiter),
        .ba_addr   (ba_addr),
        .ba_rd     (ba_rd),
        .ba_ack    (ba_ack),
        .ba_dok    (ba_dok),
        .ba_rdy    (ba_rdy),
        .data_read (data_read)
    );

endmodule

//--- hw/text_layer.sv
// pixel for column x is registered on enable x and shows one enable later; single line buffer
`timescale 1ns/1ps
`include "game_defines.svh"

module text_layer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pxl_cen,
    input  logic            LHBL,
    input  logic            LVBL,
    input  logic            flip,
    input  logic [`V_W-1:0] v,
    rom_req_if.client       rom,
    output logic [3:0]      pixel
);
    import game_pkg::*;

    localparam int V_W = `V_W;
    localparam int NW  = `LINE_WORDS;
    localparam int IW  = $clog2(`LINE_WORDS);
    localparam int CW  = $clog2(`H_ACTIVE);

    localparam logic [V_W-1:0] V_LAST   = V_W'(`V_TOTAL - 1);
    localparam logic [IW-1:0]  IDX_LAST = IW'(`LINE_WORDS - 1);
    localparam logic [CW-1:0]  COL_LAST = CW'(`H_ACTIVE - 1);

    rom_word_t      line_buf [NW];
    rom_word_t      cur_word;
    logic           lhbl_l;
    logic           hb_fall;
    logic [IW-1:0]  idx;
    logic [V_W-1:0] nxt_line;
    rom_addr_t      line_base;
    logic [CW-1:0]  col;
    logic [CW-1:0]  src;

    assign hb_fall   = lhbl_l & ~LHBL;
    assign nxt_line  = (v == V_LAST) ? '0 : v + 1'b1;
    assign line_base = rom_addr_t'(`TEXT_BASE)
                     + rom_addr_t'(nxt_line) * rom_addr_t'(`LINE_WORDS);

    // fetch control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_l <= 1'b0;
            rom.cs <= 1'b0;
            idx    <= '0;
        end else begin
            lhbl_l <= LHBL;
            if (!rom.cs) begin
                if (hb_fall) begin
                    rom.cs <= 1'b1;
                    idx    <= '0;
                end
            end else if (rom.ok) begin
                if (idx == IDX_LAST) begin
                    rom.cs <= 1'b0;
                end
                idx <= idx + 1'b1;
            end
        end
    end

    // next address goes out on the cycle after ok
    always_ff @(posedge clk) begin
        if (!rom.cs && hb_fall) begin
            rom.addr <= line_base;
        end else if (rom.cs && rom.ok) begin
            rom.addr           <= rom.addr + 1'b1;
            line_buf[idx]      <= rom.dout;
        end
    end

    // mirrored column when flipped
    assign src      = flip ? (COL_LAST - col) : col;
    assign cur_word = line_buf[src[CW-1:3]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col   <= '0;
            pixel <= 4'd0;
        end else if (pxl_cen) begin
            if (LHBL && LVBL) begin
                pixel <= cur_word.pix[src[2:0]];
                col   <= col + 1'b1;
            end else begin
                pixel <= 4'd0;
                col   <= '0;
            end
        end
    end

    // line buffer is single, so the fetch may not overlap display
    a_fetch_in_blank: assert property (
        @(posedge clk) disable iff (!rst_n)
        rom.cs |-> !LHBL
    ) else $error("text fetch still running when line starts");

endmodule

//--- hw/rom_arbiter.sv
// one burst at a time, video first; first ba_dok must come after ba_ack, ba_rdy with the second
`timescale 1ns/1ps

module rom_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    rom_req_if.arbiter            video,
    rom_req_if.arbiter            prog,
    output game_pkg::sdram_addr_t ba_addr,
    output logic                  ba_rd,
    input  logic                  ba_ack,
    input  logic                  ba_dok,
    input  logic                  ba_rdy,
    input  logic [15:0]           data_read
);
    import game_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        BEAT_LO,
        BEAT_HI
    } state_t;

    state_t    state;
    logic      gnt_video;
    logic      ok_busy;
    logic      video_req;
    logic      prog_req;
    logic      grant;
    rom_addr_t sel_addr;
    rom_word_t word_q;

    // a client still sees its old addr during its ok cycle
    assign ok_busy   = video.ok | prog.ok;
    assign video_req = video.cs & ~video.ok;
    assign prog_req  = prog.cs & ~prog.ok;
    assign grant     = (state == IDLE) && !ok_busy && (video_req || prog_req);
    assign sel_addr  = video_req ? video.addr : prog.addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            ba_rd     <= 1'b0;
            gnt_video <= 1'b0;
            video.ok  <= 1'b0;
            prog.ok   <= 1'b0;
        end else begin
            video.ok <= 1'b0;
            prog.ok  <= 1'b0;
            case (state)
                IDLE: begin
                    if (grant) begin
                        gnt_video <= video_req;
                        ba_rd     <= 1'b1;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    // hold the read until the bank takes it
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        state <= BEAT_LO;
                    end
                end
                BEAT_LO: begin
                    if (ba_dok) begin
                        state <= BEAT_HI;
                    end
                end
                BEAT_HI: begin
                    if (ba_rdy) begin
                        video.ok <= gnt_video;
                        prog.ok  <= ~gnt_video;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address and data path
    always_ff @(posedge clk) begin
        if (grant) begin
            ba_addr <= {sel_addr, 1'b0};
        end
        if (ba_dok && state == BEAT_LO) begin
            word_q.half.lo <= data_read;
        end
        if (ba_dok && state == BEAT_HI) begin
            word_q.half.hi <= data_read;
        end
    end

    assign video.dout = word_q;
    assign prog.dout  = word_q;

    a_rdy_in_burst: assert property (
        @(posedge clk) disable iff (!rst_n)
        ba_rdy |-> (state == BEAT_HI)
    ) else $error("ba_rdy without a burst in flight");

    a_video_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (video.cs && !video.ok) ##1 video.cs |-> $stable(video.addr)
    ) else $error("video addr changed while waiting");

    a_prog_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (prog.cs && !prog.ok) ##1 prog.cs |-> $stable(prog.addr)
    ) else $error("prog addr changed while waiting");

endmodule

//--- hw/video_timing.sv
// outputs are registered and move one clk after pxl_cen; the first line after reset is V_TOTAL-1
`timescale 1ns/1ps
`include "game_defines.svh"

module video_timing (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    output logic             LHBL,
    output logic             LVBL,
    output logic             HS,
    output logic             VS,
    output logic [`V_W-1:0]  v
);

    localparam int H_W = `H_W;
    localparam int V_W = `V_W;

    localparam logic [H_W-1:0] H_LAST   = H_W'(`H_TOTAL - 1);
    localparam logic [H_W-1:0] H_ACT    = H_W'(`H_ACTIVE);
    localparam logic [H_W-1:0] HS_START = H_W'(`H_ACTIVE + 4);
    localparam logic [H_W-1:0] HS_END   = H_W'(`H_ACTIVE + 7);
    localparam logic [V_W-1:0] V_LAST   = V_W'(`V_TOTAL - 1);
    localparam logic [V_W-1:0] V_ACT    = V_W'(`V_ACTIVE);
    localparam logic [V_W-1:0] VS_LINE  = V_W'(`V_ACTIVE + 2);

    logic [H_W-1:0] h;
    logic [H_W-1:0] h_nxt;
    logic [V_W-1:0] v_nxt;

    always_comb begin
        h_nxt = (h == H_LAST) ? '0 : h + 1'b1;
        v_nxt = v;
        if (h == H_LAST) begin
            v_nxt = (v == V_LAST) ? '0 : v + 1'b1;
        end
    end

    // reset parks on the last dot of line V_TOTAL-2
    // so the blank line before line 0 still triggers a text fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h    <= H_LAST;
            v    <= V_W'(`V_TOTAL - 2);
            LHBL <= 1'b0;
            LVBL <= 1'b0;
            HS   <= 1'b0;
            VS   <= 1'b0;
        end else if (pxl_cen) begin
            h    <= h_nxt;
            v    <= v_nxt;
            // windows decoded from the next count, so they line up with h and v
            LHBL <= (h_nxt < H_ACT);
            LVBL <= (v_nxt < V_ACT);
            HS   <= (h_nxt >= HS_START) && (h_nxt <= HS_END);
            VS   <= (v_nxt == VS_LINE);
        end
    end

    a_hs_in_blank: assert property (
        @(posedge clk) disable iff (!rst_n)
        HS |-> !LHBL
    ) else $error("HS active during visible part of line");

    a_v_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        v <= V_LAST
    ) else $error("line count reached V_TOTAL");

endmodule

//--- hw/cen_gen.sv
// pixel enable every PXL_DIV clocks, first one PXL_DIV clocks after reset release; PXL_DIV > 1
`timescale 1ns/1ps
`include "game_defines.svh"

module cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen
);

    localparam int CW = $clog2(`PXL_DIV);
    localparam logic [CW-1:0] CNT_LAST = CW'(`PXL_DIV - 1);

    logic [CW-1:0] cnt;

    // free running divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            pxl_cen <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // registered so the enable is glitch free
            pxl_cen <= (cnt == CNT_LAST);
        end
    end

    // video timing and text layer expect isolated single-cycle enables
    a_cen_isolated: assert property (
        @(posedge clk) disable iff (!rst_n)
        pxl_cen |=> !pxl_cen
    ) else $error("pxl_cen high on two adjacent cycles");

endmodule

//--- hw/rom_req_if.sv
// one ROM client; addr must hold while cs waits, ok is a single-cycle strobe with dout valid
`timescale 1ns/1ps

interface rom_req_if;
    import game_pkg::*;

    logic      cs;
    rom_addr_t addr;
    logic      ok;
    rom_word_t dout;

    // requesting side
    modport client (
        output cs,
        output addr,
        input  ok,
        input  dout
    );

    // serving side
    modport arbiter (
        input  cs,
        input  addr,
        output ok,
        output dout
    );

endinterface

//--- hw/game_pkg.sv
// shared ROM types; a rom word is two SDRAM beats with the first beat in the low half
package game_pkg;

    // 32-bit ROM word address
    typedef logic [20:0] rom_addr_t;

    // 16-bit SDRAM word address, twice the ROM address
    typedef logic [21:0] sdram_addr_t;

    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } rom_half_t;

    // same word seen as SDRAM beats or as tile pixels
    // pixel 0 sits in the low nibble
    typedef union packed {
        rom_half_t       half;
        logic [7:0][3:0] pix;
    } rom_word_t;

endpackage

//--- hw/game_defines.svh
// tiny geometry for short runs; H_ACTIVE must be a power of two and eight times LINE_WORDS
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// horizontal geometry, counted in pixel enables
`define H_TOTAL    48
`define H_ACTIVE   32
`define H_W        6

// vertical geometry, counted in lines
`define V_TOTAL    20
`define V_ACTIVE   16
`define V_W        5

// main clocks per pixel enable
`define PXL_DIV    4

// text tiles start at this 32-bit ROM word
`define TEXT_BASE  21'h001000

// eight 4-bit pixels per ROM word
`define LINE_WORDS (`H_ACTIVE / 8)

`endif
